// File: Makefile
VERILATOR ?= verilator
TOP       ?= exec_stage_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(wildcard source/*.sv verification/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "Test passed" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: flist.f
source/ex_pkg.sv
source/operand_select.sv
source/alu_unit.sv
source/branch_unit.sv
source/mult_unit.sv
source/completion_arbiter.sv
source/exec_stage.sv
verification/tb_clock_gen.sv
verification/exec_stage_tb.sv

// File: source/alu_unit.sv
// Single-cycle ALU; mul and mulhu steered here give zero, and a new issue overwrites the output
`timescale 1ns/1ps
`default_nettype none

module alu_unit #(
    parameter int unsigned fu_index = 0
) (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      flush,
    input  ex_pkg::issue_packet_t     issue,
    input  logic [ex_pkg::xlen-1:0]   opa,
    input  logic [ex_pkg::xlen-1:0]   opb,
    output ex_pkg::fu_result_t        result
);

    logic accept;
    logic [4:0] shamt;
    logic [ex_pkg::xlen-1:0] value;
    logic valid_q;
    logic [ex_pkg::xlen-1:0] value_q;
    logic [ex_pkg::rob_idx_w-1:0] rob_q;

    // Steered to this ALU only
    assign accept = issue.valid && (issue.fu_type == ex_pkg::fu_alu)
                    && (issue.fu_index == ex_pkg::fu_idx_w'(fu_index));
    assign shamt = opb[4:0];

    always_comb begin
        case (issue.alu_func)
            ex_pkg::alu_add:  value = opa + opb;
            ex_pkg::alu_sub:  value = opa - opb;
            ex_pkg::alu_and:  value = opa & opb;
            ex_pkg::alu_or:   value = opa | opb;
            ex_pkg::alu_xor:  value = opa ^ opb;
            ex_pkg::alu_slt:  value = {31'b0, $signed(opa) < $signed(opb)};
            ex_pkg::alu_sltu: value = {31'b0, opa < opb};
            ex_pkg::alu_sll:  value = opa << shamt;
            ex_pkg::alu_srl:  value = opa >> shamt;
            ex_pkg::alu_sra:  value = $signed(opa) >>> shamt;
            default:          value = '0;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= accept && !flush;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            value_q <= value;
            rob_q <= issue.rob_index;
        end
    end

    assign result = '{valid: valid_q, result: value_q, take_branch: 1'b0,
                      target: {ex_pkg::xlen{1'b0}}, rob_index: rob_q};

endmodule

`default_nettype wire

// File: source/branch_unit.sv
// Branch resolution in one cycle; the condition reads rs1/rs2 directly, not the selected operands
`timescale 1ns/1ps
`default_nettype none

module branch_unit #(
    parameter int unsigned fu_index = 0
) (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      flush,
    input  ex_pkg::issue_packet_t     issue,
    input  logic [ex_pkg::xlen-1:0]   opa,
    input  logic [ex_pkg::xlen-1:0]   opb,
    output ex_pkg::fu_result_t        result
);

    logic accept;
    logic cond_holds;
    logic [ex_pkg::xlen-1:0] rs1, rs2;
    logic valid_q;
    logic take_q;
    logic [ex_pkg::xlen-1:0] link_q;
    logic [ex_pkg::xlen-1:0] target_q;
    logic [ex_pkg::rob_idx_w-1:0] rob_q;

    assign accept = issue.valid && (issue.fu_type == ex_pkg::fu_branch)
                    && (issue.fu_index == ex_pkg::fu_idx_w'(fu_index));
    assign rs1 = issue.rs1_value;
    assign rs2 = issue.rs2_value;

    // Condition from funct3
    always_comb begin
        case (issue.inst[14:12])
            ex_pkg::br_eq:  cond_holds = (rs1 == rs2);
            ex_pkg::br_ne:  cond_holds = (rs1 != rs2);
            ex_pkg::br_lt:  cond_holds = ($signed(rs1) < $signed(rs2));
            ex_pkg::br_ge:  cond_holds = ($signed(rs1) >= $signed(rs2));
            ex_pkg::br_ltu: cond_holds = (rs1 < rs2);
            ex_pkg::br_geu: cond_holds = (rs1 >= rs2);
            default:        cond_holds = 1'b0;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= accept && !flush;
        end
    end

    // Link value is npc, target is the opa/opb sum (pc or rs1 plus offset)
    always_ff @(posedge clock) begin
        if (accept) begin
            take_q <= issue.uncond_branch || (issue.cond_branch && cond_holds);
            link_q <= issue.npc;
            target_q <= opa + opb;
            rob_q <= issue.rob_index;
        end
    end

    assign result = '{valid: valid_q, result: link_q, take_branch: take_q,
                      target: target_q, rob_index: rob_q};

endmodule

`default_nettype wire

// File: source/completion_arbiter.sv
// One buffer per unit with no back-pressure; a result arriving into a full buffer overwrites it
`timescale 1ns/1ps
`default_nettype none

module completion_arbiter (
    input  logic                                        clock,
    input  logic                                        rst_n,
    input  logic                                        flush,
    input  ex_pkg::fu_result_t [ex_pkg::num_alu-1:0]    alu_res,
    input  ex_pkg::fu_result_t                          mult_res,
    input  ex_pkg::fu_result_t                          branch_res,
    output ex_pkg::complete_packet_t                    complete,
    output logic [ex_pkg::num_alu-1:0]                  free_alu,
    output logic                                        free_mult,
    output logic                                        free_branch
);

    localparam int unsigned n = ex_pkg::num_fu;

    ex_pkg::fu_result_t res_all [n];
    ex_pkg::fu_result_t buf_q [n];
    logic [n-1:0] full_q;
    logic [n-1:0] grant_oh;
    logic [ex_pkg::fu_idx_w-1:0] grant_idx;
    logic grant_found;
    logic [n-1:0] free_q;
    logic complete_valid_q;
    ex_pkg::complete_packet_t complete_q;

    // Slot order is also grant priority: ALUs, multiplier, branch
    function automatic ex_pkg::fu_type_e slot_type(input logic [ex_pkg::fu_idx_w-1:0] idx);
        if (idx < ex_pkg::fu_idx_w'(ex_pkg::num_alu)) begin
            return ex_pkg::fu_alu;
        end else if (idx < ex_pkg::fu_idx_w'(ex_pkg::num_alu + ex_pkg::num_mult)) begin
            return ex_pkg::fu_mult;
        end
        return ex_pkg::fu_branch;
    endfunction

    always_comb begin
        for (int i = 0; i < ex_pkg::num_alu; i++) begin
            res_all[i] = alu_res[i];
        end
        res_all[ex_pkg::num_alu] = mult_res;
        res_all[n-1] = branch_res;
    end

    // Fixed priority, lowest slot first
    always_comb begin
        grant_found = 1'b0;
        grant_idx = '0;
        grant_oh = '0;
        for (int i = 0; i < n; i++) begin
            if (full_q[i] && !grant_found) begin
                grant_found = 1'b1;
                grant_idx = ex_pkg::fu_idx_w'(i);
                grant_oh[i] = 1'b1;
            end
        end
    end

    ////////////////////
    // Control
    ////////////////////
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            full_q <= '0;
            free_q <= '0;
            complete_valid_q <= 1'b0;
        end else if (flush) begin
            full_q <= '0;
            free_q <= '0;
            complete_valid_q <= 1'b0;
        end else begin
            complete_valid_q <= grant_found;
            free_q <= grant_oh;
            for (int i = 0; i < n; i++) begin
                if (res_all[i].valid) begin
                    full_q[i] <= 1'b1;
                end else if (grant_oh[i]) begin
                    full_q[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < n; i++) begin
            if (res_all[i].valid) begin
                buf_q[i] <= res_all[i];
            end
        end
        if (grant_found) begin
            complete_q <= '{valid: 1'b1, fu_type: slot_type(grant_idx),
                            result: buf_q[grant_idx].result,
                            take_branch: buf_q[grant_idx].take_branch,
                            target: buf_q[grant_idx].target,
                            rob_index: buf_q[grant_idx].rob_index};
        end
    end

    always_comb begin
        complete = complete_q;
        complete.valid = complete_valid_q;
    end

    assign free_alu = free_q[ex_pkg::num_alu-1:0];
    assign free_mult = free_q[ex_pkg::num_alu];
    assign free_branch = free_q[n-1];

endmodule

`default_nettype wire

// File: source/ex_pkg.sv
// Shared execute-stage types; unit counts must match the port shapes of exec_stage (one mult, one branch)
`default_nettype none

package ex_pkg;

    ////////////////////
    // Widths and counts
    ////////////////////
    localparam int unsigned xlen = 32;
    localparam int unsigned rob_idx_w = 5;
    localparam int unsigned num_alu = 2;
    localparam int unsigned num_mult = 1;
    localparam int unsigned num_branch = 1;
    localparam int unsigned num_fu = num_alu + num_mult + num_branch;
    localparam int unsigned fu_idx_w = $clog2(num_fu);

    // Stages between multiplier issue and result
    localparam int unsigned mult_latency = 4;

    // Markers for select codes with no defined operand
    localparam logic [xlen-1:0] opa_bad = 32'hdeadface;
    localparam logic [xlen-1:0] opb_bad = 32'hfacefeed;

    // Branch conditions, funct3 of the instruction word
    localparam logic [2:0] br_eq = 3'b000;
    localparam logic [2:0] br_ne = 3'b001;
    localparam logic [2:0] br_lt = 3'b100;
    localparam logic [2:0] br_ge = 3'b101;
    localparam logic [2:0] br_ltu = 3'b110;
    localparam logic [2:0] br_geu = 3'b111;

    ////////////////////
    // Encodings
    ////////////////////
    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_sltu,
        alu_sll, alu_srl, alu_sra, alu_mul, alu_mulhu
    } alu_func_e;

    typedef enum logic [1:0] {fu_alu, fu_mult, fu_branch} fu_type_e;

    typedef enum logic [1:0] {opa_rs1, opa_npc, opa_pc, opa_zero} opa_sel_e;

    typedef enum logic [2:0] {opb_rs2, opb_i_imm, opb_b_imm, opb_u_imm, opb_j_imm} opb_sel_e;

    ////////////////////
    // Packets
    ////////////////////
    typedef struct packed {
        logic                 valid;
        fu_type_e             fu_type;
        logic [fu_idx_w-1:0]  fu_index;
        alu_func_e            alu_func;
        opa_sel_e             opa_sel;
        opb_sel_e             opb_sel;
        logic [31:0]          inst;
        logic [xlen-1:0]      pc;
        logic [xlen-1:0]      npc;
        logic [xlen-1:0]      rs1_value;
        logic [xlen-1:0]      rs2_value;
        logic                 cond_branch;
        logic                 uncond_branch;
        logic [rob_idx_w-1:0] rob_index;
    } issue_packet_t;

    typedef struct packed {
        logic                 valid;
        logic [xlen-1:0]      result;
        logic                 take_branch;
        logic [xlen-1:0]      target;
        logic [rob_idx_w-1:0] rob_index;
    } fu_result_t;

    typedef struct packed {
        logic                 valid;
        fu_type_e             fu_type;
        logic [xlen-1:0]      result;
        logic                 take_branch;
        logic [xlen-1:0]      target;
        logic [rob_idx_w-1:0] rob_index;
    } complete_packet_t;

endpackage

`default_nettype wire

// File: source/exec_stage.sv
// Execute stage top; the issuer must wait for a unit's free pulse before issuing to it again
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
    input  logic                              clock,
    input  logic                              rst_n,
    input  logic                              flush,
    input  ex_pkg::issue_packet_t             issue,
    output ex_pkg::complete_packet_t          complete,
    output logic [ex_pkg::num_alu-1:0]        free_alu,
    output logic                              free_mult,
    output logic                              free_branch
);

    logic [ex_pkg::xlen-1:0] opa;
    logic [ex_pkg::xlen-1:0] opb;
    ex_pkg::fu_result_t [ex_pkg::num_alu-1:0] alu_res;
    ex_pkg::fu_result_t mult_res;
    ex_pkg::fu_result_t branch_res;

    operand_select u_operand_select (
        .issue (issue),
        .opa   (opa),
        .opb   (opb)
    );

    ////////////////////
    // Functional units
    ////////////////////
    for (genvar g = 0; g < ex_pkg::num_alu; g++) begin : g_alu
        alu_unit #(.fu_index(g)) u_alu (
            .clock  (clock),
            .rst_n  (rst_n),
            .flush  (flush),
            .issue  (issue),
            .opa    (opa),
            .opb    (opb),
            .result (alu_res[g])
        );
    end

    mult_unit #(.fu_index(0)) u_mult (
        .clock  (clock),
        .rst_n  (rst_n),
        .flush  (flush),
        .issue  (issue),
        .opa    (opa),
        .opb    (opb),
        .result (mult_res)
    );

    branch_unit #(.fu_index(0)) u_branch (
        .clock  (clock),
        .rst_n  (rst_n),
        .flush  (flush),
        .issue  (issue),
        .opa    (opa),
        .opb    (opb),
        .result (branch_res)
    );

    completion_arbiter u_arbiter (
        .clock       (clock),
        .rst_n       (rst_n),
        .flush       (flush),
        .alu_res     (alu_res),
        .mult_res    (mult_res),
        .branch_res  (branch_res),
        .complete    (complete),
        .free_alu    (free_alu),
        .free_mult   (free_mult),
        .free_branch (free_branch)
    );

endmodule

`default_nettype wire

// File: source/mult_unit.sv
// Unsigned multiply only (mul, mulhu); fixed depth pipeline, results leave in issue order
`timescale 1ns/1ps
`default_nettype none

module mult_unit #(
    parameter int unsigned fu_index = 0
) (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      flush,
    input  ex_pkg::issue_packet_t     issue,
    input  logic [ex_pkg::xlen-1:0]   opa,
    input  logic [ex_pkg::xlen-1:0]   opb,
    output ex_pkg::fu_result_t        result
);

    localparam int unsigned depth = ex_pkg::mult_latency;

    logic accept;
    logic [2*ex_pkg::xlen-1:0] product;
    logic [ex_pkg::xlen-1:0] product_sel;
    logic [depth-1:0] valid_q;
    logic [ex_pkg::xlen-1:0] value_q [depth];
    logic [ex_pkg::rob_idx_w-1:0] rob_q [depth];

    assign accept = issue.valid && (issue.fu_type == ex_pkg::fu_mult)
                    && (issue.fu_index == ex_pkg::fu_idx_w'(fu_index));

    assign product = {{ex_pkg::xlen{1'b0}}, opa} * {{ex_pkg::xlen{1'b0}}, opb};
    // High half for mulhu, low half otherwise
    assign product_sel = (issue.alu_func == ex_pkg::alu_mulhu) ?
                         product[2*ex_pkg::xlen-1:ex_pkg::xlen] : product[ex_pkg::xlen-1:0];

    ////////////////////
    // Valid chain
    ////////////////////
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (flush) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[depth-2:0], accept};
        end
    end

    // Payload shifts every cycle alongside the valid bits
    always_ff @(posedge clock) begin
        value_q[0] <= product_sel;
        rob_q[0] <= issue.rob_index;
        for (int s = 1; s < depth; s++) begin
            value_q[s] <= value_q[s-1];
            rob_q[s] <= rob_q[s-1];
        end
    end

    assign result = '{valid: valid_q[depth-1], result: value_q[depth-1], take_branch: 1'b0,
                      target: {ex_pkg::xlen{1'b0}}, rob_index: rob_q[depth-1]};

endmodule

`default_nettype wire

// File: source/operand_select.sv
// Operand muxes are purely combinational; undefined select codes give marker patterns, not errors
`timescale 1ns/1ps
`default_nettype none

module operand_select (
    input  ex_pkg::issue_packet_t    issue,
    output logic [ex_pkg::xlen-1:0]  opa,
    output logic [ex_pkg::xlen-1:0]  opb
);

    logic [31:0] inst;
    logic [ex_pkg::xlen-1:0] i_imm, b_imm, u_imm, j_imm;

    assign inst = issue.inst;

    // RV32 immediates, sign extended
    assign i_imm = {{20{inst[31]}}, inst[31:20]};
    assign b_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign u_imm = {inst[31:12], 12'b0};
    assign j_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (issue.opa_sel)
            ex_pkg::opa_rs1:  opa = issue.rs1_value;
            ex_pkg::opa_npc:  opa = issue.npc;
            ex_pkg::opa_pc:   opa = issue.pc;
            ex_pkg::opa_zero: opa = '0;
            default:          opa = ex_pkg::opa_bad;
        endcase
    end

    always_comb begin
        case (issue.opb_sel)
            ex_pkg::opb_rs2:   opb = issue.rs2_value;
            ex_pkg::opb_i_imm: opb = i_imm;
            ex_pkg::opb_b_imm: opb = b_imm;
            ex_pkg::opb_u_imm: opb = u_imm;
            ex_pkg::opb_j_imm: opb = j_imm;
            default:           opb = ex_pkg::opb_bad;
        endcase
    end

endmodule

`default_nettype wire

// File: verification/exec_stage_tb.sv
// No unit gets a second issue while its result buffer is full; at most 32 ROB tags may be in flight
`timescale 1ns/1ps
`default_nettype none

module exec_stage_tb;

    localparam int unsigned wait_limit = 200;
    localparam int unsigned n_slots = ex_pkg::num_fu;
    localparam int unsigned n_tags = 1 << ex_pkg::rob_idx_w;

    logic clock;
    logic rst_n;
    logic flush;
    ex_pkg::issue_packet_t issue;
    ex_pkg::complete_packet_t complete;
    logic [ex_pkg::num_alu-1:0] free_alu;
    logic free_mult;
    logic free_branch;
    logic [n_slots-1:0] free_vec;

    logic [31:0] rng;
    logic [ex_pkg::rob_idx_w-1:0] next_tag;

    // Scoreboard by ROB tag
    ex_pkg::fu_result_t exp_res [n_tags];
    ex_pkg::fu_type_e exp_type [n_tags];
    int unsigned exp_slot [n_tags];
    bit pending [n_tags];
    int unsigned outstanding;
    logic [ex_pkg::rob_idx_w-1:0] mult_order [$];

    tb_clock_gen #(.period_ns(20), .reset_cycles(5)) u_clock_gen (
        .clock (clock),
        .rst_n (rst_n)
    );

    exec_stage DUT (
        .clock       (clock),
        .rst_n       (rst_n),
        .flush       (flush),
        .issue       (issue),
        .complete    (complete),
        .free_alu    (free_alu),
        .free_mult   (free_mult),
        .free_branch (free_branch)
    );

    // Slot order is ALUs, then multiplier, then branch
    assign free_vec = {free_branch, free_mult, free_alu};

    ////////////////////
    // Helpers
    ////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] want);
        if (got !== want) begin
            abort_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, want));
        end
    endtask

    function automatic int unsigned slot_of(input ex_pkg::fu_type_e kind, input int unsigned idx);
        if (kind == ex_pkg::fu_alu) begin
            return idx;
        end else if (kind == ex_pkg::fu_mult) begin
            return ex_pkg::num_alu;
        end
        return ex_pkg::num_alu + ex_pkg::num_mult;
    endfunction

    ////////////////////
    // Reference model
    ////////////////////
    function automatic ex_pkg::fu_result_t ref_result(input ex_pkg::issue_packet_t p);
        ex_pkg::fu_result_t r;
        logic [31:0] a, b;
        logic [31:0] i_imm, b_imm, u_imm, j_imm;
        logic [63:0] prod;
        logic taken;
        r = '0;
        r.valid = 1'b1;
        r.rob_index = p.rob_index;
        i_imm = 32'($signed(p.inst[31:20]));
        b_imm = 32'($signed({p.inst[31], p.inst[7], p.inst[30:25], p.inst[11:8], 1'b0}));
        u_imm = {p.inst[31:12], 12'h000};
        j_imm = 32'($signed({p.inst[31], p.inst[19:12], p.inst[20], p.inst[30:21], 1'b0}));
        case (p.opa_sel)
            ex_pkg::opa_rs1: a = p.rs1_value;
            ex_pkg::opa_npc: a = p.npc;
            ex_pkg::opa_pc:  a = p.pc;
            default:         a = 32'h0;
        endcase
        case (p.opb_sel)
            ex_pkg::opb_rs2:   b = p.rs2_value;
            ex_pkg::opb_i_imm: b = i_imm;
            ex_pkg::opb_b_imm: b = b_imm;
            ex_pkg::opb_u_imm: b = u_imm;
            ex_pkg::opb_j_imm: b = j_imm;
            default:           b = 32'hfacefeed;
        endcase
        if (p.fu_type == ex_pkg::fu_mult) begin
            prod = 64'(a) * 64'(b);
            r.result = (p.alu_func == ex_pkg::alu_mulhu) ? prod[63:32] : prod[31:0];
        end else if (p.fu_type == ex_pkg::fu_branch) begin
            // Condition on the raw register values by funct3
            case (p.inst[14:12])
                3'b000:  taken = (p.rs1_value == p.rs2_value);
                3'b001:  taken = (p.rs1_value != p.rs2_value);
                3'b100:  taken = ($signed(p.rs1_value) < $signed(p.rs2_value));
                3'b101:  taken = ($signed(p.rs1_value) >= $signed(p.rs2_value));
                3'b110:  taken = (p.rs1_value < p.rs2_value);
                3'b111:  taken = (p.rs1_value >= p.rs2_value);
                default: taken = 1'b0;
            endcase
            r.result = p.npc;
            r.target = a + b;
            r.take_branch = p.uncond_branch | (p.cond_branch & taken);
        end else begin
            case (p.alu_func)
                ex_pkg::alu_add:  r.result = a + b;
                ex_pkg::alu_sub:  r.result = a - b;
                ex_pkg::alu_and:  r.result = a & b;
                ex_pkg::alu_or:   r.result = a | b;
                ex_pkg::alu_xor:  r.result = a ^ b;
                ex_pkg::alu_slt:  r.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                ex_pkg::alu_sltu: r.result = (a < b) ? 32'd1 : 32'd0;
                ex_pkg::alu_sll:  r.result = a << b[4:0];
                ex_pkg::alu_srl:  r.result = a >> b[4:0];
                ex_pkg::alu_sra:  r.result = $signed(a) >>> b[4:0];
                default:          r.result = 32'h0;
            endcase
        end
        return r;
    endfunction

    ////////////////////
    // Stimulus
    ////////////////////
    function automatic ex_pkg::issue_packet_t new_packet(input ex_pkg::fu_type_e kind,
                                                         input int unsigned idx);
        ex_pkg::issue_packet_t p;
        p = '0;
        p.valid = 1'b1;
        p.fu_type = kind;
        p.fu_index = ex_pkg::fu_idx_w'(idx);
        p.alu_func = ex_pkg::alu_add;
        p.inst = next_rand();
        p.pc = next_rand() & 32'hffff_fffc;
        p.npc = p.pc + 32'd4;
        p.rs1_value = next_rand();
        p.rs2_value = next_rand();
        p.rob_index = next_tag;
        next_tag++;
        return p;
    endfunction

    // Random work for one unit slot
    function automatic ex_pkg::issue_packet_t packet_for_slot(input int unsigned slot);
        ex_pkg::issue_packet_t p;
        if (slot < ex_pkg::num_alu) begin
            p = new_packet(ex_pkg::fu_alu, slot);
            p.alu_func = ex_pkg::alu_func_e'(4'(next_rand() % 10));
        end else if (slot == ex_pkg::num_alu) begin
            p = new_packet(ex_pkg::fu_mult, 0);
            p.alu_func = (next_rand() & 32'd1) ? ex_pkg::alu_mulhu : ex_pkg::alu_mul;
        end else begin
            p = new_packet(ex_pkg::fu_branch, 0);
            // lt, ge, ltu or geu
            p.inst[14] = 1'b1;
            p.cond_branch = 1'b1;
            p.opa_sel = ex_pkg::opa_pc;
            p.opb_sel = ex_pkg::opb_b_imm;
        end
        return p;
    endfunction

    task automatic send(input ex_pkg::issue_packet_t pkt);
        logic [ex_pkg::rob_idx_w-1:0] tag;
        tag = pkt.rob_index;
        @(posedge clock);
        if (pending[tag]) begin
            abort_run($sformatf("ROB tag %0d reused while still in flight", tag));
        end
        exp_res[tag] = ref_result(pkt);
        exp_type[tag] = pkt.fu_type;
        exp_slot[tag] = slot_of(pkt.fu_type, pkt.fu_index);
        pending[tag] = 1'b1;
        outstanding++;
        if (pkt.fu_type == ex_pkg::fu_mult) begin
            mult_order.push_back(tag);
        end
        issue <= pkt;
    endtask

    task automatic go_idle();
        @(posedge clock);
        issue <= '0;
    endtask

    task automatic wait_free(input int unsigned slot);
        int unsigned cycles;
        bit seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen) begin
            if (cycles == wait_limit) begin
                abort_run($sformatf("no free pulse from unit slot %0d in time", slot));
            end
            @(negedge clock);
            seen = free_vec[slot];
            cycles++;
        end
    endtask

    task automatic issue_and_wait(input ex_pkg::issue_packet_t pkt);
        send(pkt);
        go_idle();
        wait_free(slot_of(pkt.fu_type, pkt.fu_index));
    endtask

    task automatic drain();
        int unsigned cycles;
        cycles = 0;
        while (outstanding != 0) begin
            if (cycles == wait_limit) begin
                abort_run($sformatf("%0d results never completed", outstanding));
            end
            @(posedge clock);
            cycles++;
        end
    endtask

    task automatic wait_reset_release();
        int unsigned cycles;
        cycles = 0;
        while (rst_n !== 1'b1) begin
            if (cycles == wait_limit) begin
                abort_run("reset was never released");
            end
            @(posedge clock);
            cycles++;
        end
    endtask

    ////////////////////
    // Monitor
    ////////////////////
    task automatic check_cycle();
        logic [ex_pkg::rob_idx_w-1:0] tag;
        logic [n_slots-1:0] want_free;
        if (complete.valid === 1'b1) begin
            tag = complete.rob_index;
            if (!pending[tag]) begin
                abort_run($sformatf("completion for tag %0d, which is not in flight", tag));
            end
            want_free = '0;
            want_free[exp_slot[tag]] = 1'b1;
            check_value("free_alu/free_mult/free_branch", 64'(free_vec), 64'(want_free));
            check_value("complete.fu_type", 64'(complete.fu_type), 64'(exp_type[tag]));
            check_value("complete.result", 64'(complete.result), 64'(exp_res[tag].result));
            check_value("complete.take_branch", 64'(complete.take_branch),
                        64'(exp_res[tag].take_branch));
            if (exp_type[tag] == ex_pkg::fu_branch) begin
                check_value("complete.target", 64'(complete.target), 64'(exp_res[tag].target));
            end
            if (exp_type[tag] == ex_pkg::fu_mult) begin
                if (mult_order.size() == 0) begin
                    abort_run("multiplier completion with no multiply in flight");
                end
                check_value("complete.rob_index", 64'(tag), 64'(mult_order[0]));
                void'(mult_order.pop_front());
            end
            pending[tag] = 1'b0;
            outstanding--;
        end else begin
            check_value("complete.valid", 64'(complete.valid), 64'd0);
            check_value("free_alu/free_mult/free_branch", 64'(free_vec), 64'd0);
        end
    endtask

    // Compare on every falling edge from the first clock period on
    initial begin
        @(posedge clock);
        forever begin
            @(negedge clock);
            check_cycle();
        end
    end

    ////////////////////
    // Tests
    ////////////////////
    task automatic run_alu_tests();
        ex_pkg::issue_packet_t p;
        for (int i = 0; i < 40; i++) begin
            p = packet_for_slot(next_rand() % ex_pkg::num_alu);
            // Walk every operand select pair
            p.opa_sel = ex_pkg::opa_sel_e'(2'(i % 4));
            p.opb_sel = ex_pkg::opb_sel_e'(3'(i % 5));
            issue_and_wait(p);
        end
        drain();
    endtask

    task automatic run_mult_tests();
        ex_pkg::issue_packet_t p;
        for (int round = 0; round < 3; round++) begin
            for (int unsigned k = 0; k < ex_pkg::mult_latency; k++) begin
                p = packet_for_slot(ex_pkg::num_alu);
                p.opb_sel = (next_rand() & 32'd1) ? ex_pkg::opb_u_imm : ex_pkg::opb_rs2;
                send(p);
            end
            go_idle();
            drain();
        end
    endtask

    task automatic run_branch_tests();
        ex_pkg::issue_packet_t p;
        logic [31:0] base;
        for (int f = 0; f < 8; f++) begin
            if (f == 2 || f == 3) begin
                continue;
            end
            for (int c = 0; c < 4; c++) begin
                base = next_rand() >> 2;
                p = packet_for_slot(ex_pkg::num_alu + 1);
                p.inst[14:12] = 3'(f);
                case (c)
                    0: begin
                        p.rs1_value = base;
                        p.rs2_value = base;
                    end
                    1: begin
                        p.rs1_value = base;
                        p.rs2_value = base + 32'd1;
                    end
                    2: begin
                        p.rs1_value = base + 32'd1;
                        p.rs2_value = base;
                    end
                    // Signed less but unsigned greater
                    default: begin
                        p.rs1_value = 32'hffff_fff0;
                        p.rs2_value = 32'h10;
                    end
                endcase
                issue_and_wait(p);
            end
        end
        // Unconditional jumps alternating jal and jalr
        for (int j = 0; j < 4; j++) begin
            p = packet_for_slot(ex_pkg::num_alu + 1);
            p.cond_branch = 1'b0;
            p.uncond_branch = 1'b1;
            p.opa_sel = (j % 2 == 0) ? ex_pkg::opa_pc : ex_pkg::opa_rs1;
            p.opb_sel = (j % 2 == 0) ? ex_pkg::opb_j_imm : ex_pkg::opb_i_imm;
            issue_and_wait(p);
        end
        drain();
    endtask

    task automatic run_contention_tests();
        int unsigned slot;
        int unsigned gap;
        for (int unsigned round = 0; round < 6; round++) begin
            // Multiply goes first so its late result meets the single-cycle results
            gap = round % (ex_pkg::mult_latency - 1);
            send(packet_for_slot(ex_pkg::num_alu));
            for (int unsigned g = 0; g < gap; g++) begin
                go_idle();
            end
            for (int unsigned k = 0; k < n_slots; k++) begin
                slot = (round % 2 == 0) ? k : n_slots - 1 - k;
                if (slot != ex_pkg::num_alu) begin
                    send(packet_for_slot(slot));
                end
            end
            go_idle();
            drain();
        end
    endtask

    task automatic run_flush_test();
        send(packet_for_slot(ex_pkg::num_alu));
        send(packet_for_slot(ex_pkg::num_alu + 1));
        send(packet_for_slot(0));
        // Last issue arrives in the flush cycle itself
        send(packet_for_slot(1));
        flush <= 1'b1;
        // Nothing issued so far may complete from here on
        for (int t = 0; t < n_tags; t++) begin
            pending[t] = 1'b0;
        end
        outstanding = 0;
        mult_order.delete();
        @(posedge clock);
        issue <= '0;
        flush <= 1'b0;
        repeat (15) @(posedge clock);
        issue_and_wait(packet_for_slot(1));
        drain();
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        issue = '0;
        flush = 1'b0;
        rng = 32'd77572;
        next_tag = '0;
        outstanding = 0;

        wait_reset_release();
        repeat (5) @(posedge clock);

        run_alu_tests();
        run_mult_tests();
        run_branch_tests();
        run_contention_tests();
        run_flush_test();

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
// Clock runs from time zero; rst_n is held low for reset_cycles rising edges, then released on one
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int unsigned period_ns = 20,
    parameter int unsigned reset_cycles = 5
) (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #(period_ns / 2) clock = ~clock;
    end

    // Release lines up with a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire
